// File: logic/ship_ctrl_pkg.sv
// ship control shared definitions
`default_nettype none

package ship_ctrl_pkg;

	// playfield, in pixels
	localparam int screen_w = 160;
	localparam int screen_h = 120;

	// ship centre, bullet returns here on a heading key
	localparam logic [7:0] ship_x0 = 8'd80;
	localparam logic [6:0] ship_y0 = 7'd60;

	// one ps/2 scan code byte
	typedef logic [7:0] scan_t;

	// set 2 make codes
	localparam scan_t code_break = 8'hf0; // key release prefix
	localparam scan_t code_w     = 8'h1d; // heading up
	localparam scan_t code_a     = 8'h1c; // heading left
	localparam scan_t code_s     = 8'h1b; // heading down
	localparam scan_t code_d     = 8'h23; // heading right
	localparam scan_t code_space = 8'h29; // fire

	// 11-bit ps/2 frame
	// raw is the shift register view, fields is the decoded view
	typedef union packed {
		logic [10:0] raw;
		struct packed {
			logic  stop;   // last bit in, ends up on top
			logic  parity; // odd, not checked
			scan_t data;   // lsb first on the wire
			logic  start;  // first bit in, ends up at bit 0
		} fields;
	} frame_t;

	// ship heading, up is the reset value
	typedef enum logic [1:0] {
		head_up,
		head_right,
		head_down,
		head_left
	} heading_t;

	// pixel position on the playfield
	typedef struct packed {
		logic [7:0] x; // 0..159
		logic [6:0] y; // 0..119
	} pos_t;

	// everything the command stage keeps
	typedef struct packed {
		heading_t heading;
		pos_t     bullet;
	} ship_state_t;

endpackage

`default_nettype wire

// File: logic/ps2_line_filter.sv
// ps2 line synchronizer and filter
`default_nettype none

module ps2_line_filter #(
	parameter int FILTER_LEN = 8 // samples that must agree
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  ps2_clk,  // raw keyboard clock
	input  wire  ps2_data, // raw keyboard data
	output logic fall,     // one cycle, filtered clock went 1 to 0
	output logic data      // synchronized data level
);

	logic [1:0]            clk_sync;  // two flop synchronizer
	logic [1:0]            data_sync;
	logic [FILTER_LEN-1:0] samples;   // newest sample on top
	logic                  level;     // filtered clock level
	logic                  level_d;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			clk_sync  <= '0;
			data_sync <= '0;
			samples   <= '0;
			level     <= 1'b0; // first fall needs a stable high first
		end
		else
		begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			samples   <= {clk_sync[1], samples[FILTER_LEN-1:1]}; // shift right
			level     <= level_d;
		end
	end

	// level only moves when every sample agrees
	always_comb
	begin
		level_d = level;
		if (&samples)
			level_d = 1'b1;
		else if (~|samples)
			level_d = 1'b0;
	end

	assign fall = level & ~level_d; // strobe in the cycle the level drops
	assign data = data_sync[1];

endmodule

`default_nettype wire

// File: logic/ps2_frame_rx.sv
// ps2 frame receiver
`default_nettype none

module ps2_frame_rx (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  fall,       // filtered clock falling edge
	input  wire                  data,       // synchronized data bit
	output logic                 frame_done, // one cycle, code is valid
	output ship_ctrl_pkg::scan_t code        // held until next frame shifts in
);

	import ship_ctrl_pkg::*;

	typedef enum logic {
		st_idle,
		st_rx
	} state_t;

	state_t     state;
	state_t     state_d;
	logic [3:0] count;   // bits still to come after start
	logic [3:0] count_d;
	frame_t     frame_q; // shift register, start bit ends at bit 0

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= st_idle;
			count <= '0;
		end
		else
		begin
			state <= state_d;
			count <= count_d;
		end
	end

	// every fall shifts one bit in from the top, start bit included
	always_ff @(posedge clk)
	begin
		if (fall)
			frame_q.raw <= {data, frame_q.raw[10:1]};
	end

	always_comb
	begin
		state_d    = state;
		count_d    = count;
		frame_done = 1'b0;
		case (state)
			st_idle:
			begin
				if (fall) // start bit
				begin
					count_d = 4'd10; // 8 data, parity, stop
					state_d = st_rx;
				end
			end
			st_rx:
			begin
				if (count == 4'd0) // stop bit already in
				begin
					frame_done = 1'b1;
					state_d    = st_idle;
				end
				else if (fall)
					count_d = count - 4'd1;
			end
			default: state_d = st_idle;
		endcase
	end

	assign code = frame_q.fields.data; // data byte sits at bits 8:1

endmodule

`default_nettype wire

// File: logic/key_event_filter.sv
// key press filter
`default_nettype none

module key_event_filter (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  frame_done, // new scan code
	input  wire  ship_ctrl_pkg::scan_t code,
	output logic                 key_valid,  // one cycle, make code on key
	output ship_ctrl_pkg::scan_t key
);

	import ship_ctrl_pkg::*;

	typedef enum logic {
		st_pass, // forward make codes
		st_skip  // eat the code after f0
	} state_t;

	state_t state;
	logic   take; // make code accepted this cycle

	assign take = frame_done && (state == st_pass) && (code != code_break);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state     <= st_pass;
			key_valid <= 1'b0;
		end
		else
		begin
			key_valid <= take; // exactly one cycle after frame_done
			if (frame_done)
			begin
				case (state)
					st_pass: if (code == code_break) state <= st_skip;
					st_skip: state <= st_pass; // release code dropped
					default: state <= st_pass;
				endcase
			end
		end
	end

	// hold the last make code
	always_ff @(posedge clk)
	begin
		if (take)
			key <= code;
	end

endmodule

`default_nettype wire

// File: logic/ship_command.sv
// ship heading and bullet control
`default_nettype none

module ship_command #(
	parameter int BULLET_STEP = 1 // pixels per space press
) (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         key_valid,
	input  wire  ship_ctrl_pkg::scan_t  key,
	output ship_ctrl_pkg::ship_state_t  ship
);

	import ship_ctrl_pkg::*;

	localparam logic [7:0] x_max  = 8'(screen_w - 1); // 159
	localparam logic [6:0] y_max  = 7'(screen_h - 1); // 119
	localparam logic [7:0] step_x = 8'(BULLET_STEP);
	localparam logic [6:0] step_y = 7'(BULLET_STEP);
	localparam pos_t       home   = '{x: ship_x0, y: ship_y0};

	ship_state_t ship_d;

	always_comb
	begin
		ship_d = ship; // unknown codes change nothing
		if (key_valid)
		begin
			case (key)
				code_w:
				begin
					ship_d.heading = head_up;
					ship_d.bullet  = home;
				end
				code_d:
				begin
					ship_d.heading = head_right;
					ship_d.bullet  = home;
				end
				code_s:
				begin
					ship_d.heading = head_down;
					ship_d.bullet  = home;
				end
				code_a:
				begin
					ship_d.heading = head_left;
					ship_d.bullet  = home;
				end
				code_space:
				begin
					// move along heading, clamp at the edges
					case (ship.heading)
						head_up:
							ship_d.bullet.y = (ship.bullet.y < step_y) ? 7'd0
								: ship.bullet.y - step_y;
						head_right:
							ship_d.bullet.x = (ship.bullet.x > x_max - step_x) ? x_max
								: ship.bullet.x + step_x;
						head_down:
							ship_d.bullet.y = (ship.bullet.y > y_max - step_y) ? y_max
								: ship.bullet.y + step_y;
						head_left:
							ship_d.bullet.x = (ship.bullet.x < step_x) ? 8'd0
								: ship.bullet.x - step_x;
						default: ship_d.bullet = ship.bullet;
					endcase
				end
				default: ship_d = ship;
			endcase
		end
	end

	// one cycle after key_valid
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ship <= '{heading: head_up, bullet: home};
		else
			ship <= ship_d;
	end

endmodule

`default_nettype wire

// File: logic/bullet_display.sv
// bullet position hex display
`default_nettype none

module bullet_display (
	input  wire                  clk,
	input  wire                  reset,
	input  wire  ship_ctrl_pkg::pos_t bullet,
	output logic [6:0]           hex_x_hi, // segments active low
	output logic [6:0]           hex_x_lo,
	output logic [6:0]           hex_y_hi,
	output logic [6:0]           hex_y_lo
);

	import ship_ctrl_pkg::*;

	// hex digit to segments, bit 0 is segment a
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		case (digit)
			4'h0: seg7 = 7'b1000000;
			4'h1: seg7 = 7'b1111001;
			4'h2: seg7 = 7'b0100100;
			4'h3: seg7 = 7'b0110000;
			4'h4: seg7 = 7'b0011001;
			4'h5: seg7 = 7'b0010010;
			4'h6: seg7 = 7'b0000010;
			4'h7: seg7 = 7'b1111000;
			4'h8: seg7 = 7'b0000000;
			4'h9: seg7 = 7'b0011000;
			4'ha: seg7 = 7'b0001000;
			4'hb: seg7 = 7'b0000011; // lower case b
			4'hc: seg7 = 7'b1000110;
			4'hd: seg7 = 7'b0100001; // lower case d
			4'he: seg7 = 7'b0000110;
			default: seg7 = 7'b0001110; // f
		endcase
	endfunction

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			// show the reset bullet point, 50 3c
			hex_x_hi <= seg7(ship_x0[7:4]);
			hex_x_lo <= seg7(ship_x0[3:0]);
			hex_y_hi <= seg7({1'b0, ship_y0[6:4]});
			hex_y_lo <= seg7(ship_y0[3:0]);
		end
		else
		begin
			hex_x_hi <= seg7(bullet.x[7:4]);
			hex_x_lo <= seg7(bullet.x[3:0]);
			hex_y_hi <= seg7({1'b0, bullet.y[6:4]}); // y has only 3 upper bits
			hex_y_lo <= seg7(bullet.y[3:0]);
		end
	end

endmodule

`default_nettype wire

// File: logic/ship_ctrl_top.sv
// ps2 ship control top level
`default_nettype none

module ship_ctrl_top #(
	parameter int FILTER_LEN  = 8, // ps2 clock glitch filter depth
	parameter int BULLET_STEP = 1  // bullet pixels per shot
) (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        ps2_clk,
	input  wire                        ps2_data,
	output ship_ctrl_pkg::ship_state_t ship,
	output logic [6:0]                 hex_x_hi,
	output logic [6:0]                 hex_x_lo,
	output logic [6:0]                 hex_y_hi,
	output logic [6:0]                 hex_y_lo
);

	import ship_ctrl_pkg::*;

	logic  fall;       // filtered ps2 clock edge
	logic  rx_bit;     // synchronized ps2 data
	logic  frame_done;
	scan_t code;       // every received byte
	logic  key_valid;
	scan_t key;        // make codes only

	ps2_line_filter #(
		.FILTER_LEN (FILTER_LEN)
	) i_line_filter (
		.clk      (clk),
		.reset    (reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.fall     (fall),
		.data     (rx_bit)
	);

	ps2_frame_rx i_frame_rx (
		.clk        (clk),
		.reset      (reset),
		.fall       (fall),
		.data       (rx_bit),
		.frame_done (frame_done),
		.code       (code)
	);

	key_event_filter i_key_filter (
		.clk        (clk),
		.reset      (reset),
		.frame_done (frame_done),
		.code       (code),
		.key_valid  (key_valid),
		.key        (key)
	);

	ship_command #(
		.BULLET_STEP (BULLET_STEP)
	) i_command (
		.clk       (clk),
		.reset     (reset),
		.key_valid (key_valid),
		.key       (key),
		.ship      (ship)
	);

	// display follows the bullet only
	bullet_display i_display (
		.clk      (clk),
		.reset    (reset),
		.bullet   (ship.bullet),
		.hex_x_hi (hex_x_hi),
		.hex_x_lo (hex_x_lo),
		.hex_y_hi (hex_y_hi),
		.hex_y_lo (hex_y_lo)
	);

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// testbench clock and reset
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 20, // ns
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		reset = 1'b1; // held from time zero
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0; // released just after an edge
	end

endmodule

`default_nettype wire

// File: tb/tb_ship_ctrl.sv
// ship control testbench
`default_nettype none

module tb_ship_ctrl;

	timeunit 1ns;
	timeprecision 1ps;

	import ship_ctrl_pkg::*;

	localparam int clk_period   = 20;  // ns
	localparam int bullet_step  = 2;
	localparam int x_limit      = 159; // right edge
	localparam int y_limit      = 119; // bottom edge
	localparam int home_x       = 80;
	localparam int home_y       = 60;
	localparam int half_bit     = 40;  // ps2 clock half period, in clk cycles
	localparam int settle       = 200; // clocks after each key
	localparam int fire_presses = 42;  // enough to run into the right edge
	localparam int n_random     = 20;
	// bytes sent over the whole run
	localparam int bytes_total  = 7 + (1 + fire_presses) + 5 + (3 * n_random + 1) + 1;
	localparam longint timeout_ns = longint'(bytes_total) * 11 * 2 * half_bit * clk_period
		+ longint'(bytes_total) * settle * clk_period + 50_000;

	logic        clk;
	logic        reset;
	logic        ps2_clk;
	logic        ps2_data;
	ship_state_t ship;
	logic [6:0]  hex_x_hi;
	logic [6:0]  hex_x_lo;
	logic [6:0]  hex_y_hi;
	logic [6:0]  hex_y_lo;

	// reference model of the ship
	heading_t exp_heading;
	int       exp_x;
	int       exp_y;
	bit       exp_skip; // next byte belongs to a release

	int n_checks;
	int n_errors;
	int n_tests;
	int errors_at_start;

	tb_clock #(
		.PERIOD       (clk_period),
		.RESET_CYCLES (5)
	) i_clock (
		.clk   (clk),
		.reset (reset)
	);

	ship_ctrl_top #(
		.FILTER_LEN  (8),
		.BULLET_STEP (bullet_step)
	) i_dut (
		.clk      (clk),
		.reset    (reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.ship     (ship),
		.hex_x_hi (hex_x_hi),
		.hex_x_lo (hex_x_lo),
		.hex_y_hi (hex_y_hi),
		.hex_y_lo (hex_y_lo)
	);

	// active low digit patterns, bit 0 is segment a
	function automatic logic [6:0] seg_expected(input int digit);
		case (digit)
			0:  return 7'b1000000;
			1:  return 7'b1111001;
			2:  return 7'b0100100;
			3:  return 7'b0110000;
			4:  return 7'b0011001;
			5:  return 7'b0010010;
			6:  return 7'b0000010;
			7:  return 7'b1111000;
			8:  return 7'b0000000;
			9:  return 7'b0011000;
			10: return 7'b0001000;
			11: return 7'b0000011;
			12: return 7'b1000110;
			13: return 7'b0100001;
			14: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	function automatic bit is_command_code(input logic [7:0] c);
		return (c == code_break) || (c == code_w) || (c == code_a) || (c == code_s)
			|| (c == code_d) || (c == code_space);
	endfunction

	// land 1 ns after a rising edge
	task automatic step_clocks(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		n_checks++;
		if (expected !== actual)
		begin
			n_errors++;
			$display("error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// make codes update heading and bullet
	task automatic apply_key(input logic [7:0] c);
		case (c)
			code_w:
			begin
				exp_heading = head_up;
				exp_x = home_x;
				exp_y = home_y;
			end
			code_d:
			begin
				exp_heading = head_right;
				exp_x = home_x;
				exp_y = home_y;
			end
			code_s:
			begin
				exp_heading = head_down;
				exp_x = home_x;
				exp_y = home_y;
			end
			code_a:
			begin
				exp_heading = head_left;
				exp_x = home_x;
				exp_y = home_y;
			end
			code_space:
			begin
				case (exp_heading)
					head_up:    exp_y = (exp_y - bullet_step < 0) ? 0 : exp_y - bullet_step;
					head_right: exp_x = (exp_x + bullet_step > x_limit) ? x_limit
						: exp_x + bullet_step;
					head_down:  exp_y = (exp_y + bullet_step > y_limit) ? y_limit
						: exp_y + bullet_step;
					default:    exp_x = (exp_x - bullet_step < 0) ? 0 : exp_x - bullet_step;
				endcase
			end
			default: ; // ignored key
		endcase
	endtask

	// break prefix swallows the byte after it
	task automatic model_byte(input logic [7:0] b);
		if (exp_skip)
			exp_skip = 1'b0;
		else if (b == code_break)
			exp_skip = 1'b1;
		else
			apply_key(b);
	endtask

	// keyboard side of the bus, data moves while ps2_clk is high
	task automatic send_byte(input logic [7:0] b);
		logic [10:0] bits;
		bits = {1'b1, ~^b, b, 1'b0}; // stop, odd parity, data, start
		for (int i = 0; i < 11; i++)
		begin
			step_clocks(half_bit / 2);
			ps2_data = bits[i];
			step_clocks(half_bit / 2);
			ps2_clk = 1'b0;
			step_clocks(half_bit);
			ps2_clk = 1'b1;
		end
	endtask

	task automatic check_state(input string name);
		compare_value({name, " heading"}, int'(exp_heading), int'(ship.heading));
		compare_value({name, " x"}, exp_x, ship.bullet.x);
		compare_value({name, " y"}, exp_y, ship.bullet.y);
		compare_value({name, " hex_x_hi"}, seg_expected(exp_x / 16), hex_x_hi);
		compare_value({name, " hex_x_lo"}, seg_expected(exp_x % 16), hex_x_lo);
		compare_value({name, " hex_y_hi"}, seg_expected(exp_y / 16), hex_y_hi);
		compare_value({name, " hex_y_lo"}, seg_expected(exp_y % 16), hex_y_lo);
	endtask

	task automatic press_key(input string name, input logic [7:0] b);
		send_byte(b);
		model_byte(b);
		step_clocks(settle);
		check_state(name);
	endtask

	task automatic start_test();
		errors_at_start = n_errors;
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("test %s done, %0d errors", name, n_errors - errors_at_start);
	endtask

	task automatic test_reset();
		start_test();
		check_state("reset"); // 80,60 shows as 5 0 3 c
		end_test("reset");
	endtask

	task automatic test_heading_keys();
		start_test();
		press_key("heading d", code_d);
		press_key("heading fire 1", code_space); // move off home first
		press_key("heading s", code_s);
		press_key("heading fire 2", code_space);
		press_key("heading a", code_a);
		press_key("heading fire 3", code_space);
		press_key("heading w", code_w);
		end_test("heading_keys");
	endtask

	task automatic test_firing();
		start_test();
		press_key("firing d", code_d);
		for (int i = 0; i < fire_presses; i++)
			press_key($sformatf("firing press %0d", i), code_space);
		compare_value("firing edge x", x_limit, ship.bullet.x); // stuck at 159
		end_test("firing");
	endtask

	task automatic test_break_codes();
		start_test();
		press_key("break d", code_d);
		press_key("break f0 1", code_break);
		press_key("break w", code_w);      // release, heading stays right
		press_key("break f0 2", code_break);
		press_key("break space", code_space); // no shot
		end_test("break_codes");
	endtask

	task automatic test_unknown_codes();
		logic [7:0] c;
		start_test();
		for (int i = 0; i < n_random; i++)
		begin
			do
				c = 8'($urandom_range(255, 0));
			while (is_command_code(c));
			press_key($sformatf("unknown make %0h", c), c);
			press_key($sformatf("unknown f0 %0h", c), code_break);
			press_key($sformatf("unknown release %0h", c), c);
		end
		press_key("unknown then w", code_w); // still listens
		end_test("unknown_codes");
	endtask

	task automatic test_glitch_filter();
		start_test();
		step_clocks(1);
		ps2_clk = 1'b0; // short low pulse, shorter than the filter
		step_clocks(3);
		ps2_clk = 1'b1;
		step_clocks(20);
		press_key("glitch space", code_space);
		compare_value("glitch single shot y", home_y - bullet_step, ship.bullet.y);
		end_test("glitch_filter");
	endtask

	// watchdog
	initial
	begin
		#(timeout_ns);
		$display("watchdog: run did not finish within %0d ns", timeout_ns);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		ps2_clk         = 1'b1; // bus idles high
		ps2_data        = 1'b1;
		exp_heading     = head_up;
		exp_x           = home_x;
		exp_y           = home_y;
		exp_skip        = 1'b0;
		n_checks        = 0;
		n_errors        = 0;
		n_tests         = 0;
		errors_at_start = 0;
		void'($urandom(78851));
		wait (reset === 1'b0);
		step_clocks(20); // filter sees a stable high line
		test_reset();
		test_heading_keys();
		test_firing();
		test_break_codes();
		test_unknown_codes();
		test_glitch_filter();
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
logic/ship_ctrl_pkg.sv
logic/ps2_line_filter.sv
logic/ps2_frame_rx.sv
logic/key_event_filter.sv
logic/ship_command.sv
logic/bullet_display.sv
logic/ship_ctrl_top.sv
tb/tb_clock.sv
tb/tb_ship_ctrl.sv

// File: Bender.yml
package:
  name: ship_ctrl

sources:
  - logic/ship_ctrl_pkg.sv
  - logic/ps2_line_filter.sv
  - logic/ps2_frame_rx.sv
  - logic/key_event_filter.sv
  - logic/ship_command.sv
  - logic/bullet_display.sv
  - logic/ship_ctrl_top.sv
  - target: simulation
    files:
      - tb/tb_clock.sv
      - tb/tb_ship_ctrl.sv
